// ==== all.f ====
+incdir+src
src/umtrx_ctrl_pkg.sv
src/settings_bus.sv
src/setting_reg.sv
src/boot_ctrl.sv
src/vita_timer.sv
src/misc_ctrl_regs.sv
src/readback_mux.sv
src/umtrx_ctrl_top.sv
verification/ctrl_checker.sv
verification/tb_umtrx_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line shows up
verilator --binary --timing --timescale 1ns/100ps --top-module tb_umtrx_ctrl \
   -Mdir obj_dir -f all.f \
   && ./obj_dir/Vtb_umtrx_ctrl | tee /dev/stderr | grep -qx "Simulation finished: PASS" \
   && exit 0 \
   || exit 1

// ==== src/boot_ctrl.sv ====
// Bootloader handoff FSM producing the bus reset and the boot done flag
module boot_ctrl (
   input  logic wb_clk,
   input  logic por_rst,
   input  logic bldr_done_i,
   output logic bus_rst_o,
   output logic boot_done_o
);

   import umtrx_ctrl_pkg::*;

   boot_state_t state;

   //////////////////////////////////////////////////
   // Handoff FSM

   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         state     <= BOOT_WAIT;
         bus_rst_o <= 1'b1;
      end else begin
         case (state)
            BOOT_WAIT: begin
               bus_rst_o <= 1'b0;
               // Bootloader finished, clear the bus once
               if (bldr_done_i) begin
                  state     <= BOOT_DONE;
                  bus_rst_o <= 1'b1;
               end
            end
            BOOT_DONE: begin
               // Terminal until the next power-on reset
               bus_rst_o <= 1'b0;
            end
            default: begin
               state     <= BOOT_WAIT;
               bus_rst_o <= 1'b1;
            end
         endcase
      end
   end

   assign boot_done_o = (state == BOOT_DONE);

endmodule

// ==== src/misc_ctrl_regs.sv ====
// Misc and diversity settings registers with the LED source mux
`include "umtrx_ctrl_cfg.svh"

module misc_ctrl_regs (
   input  logic                       wb_clk,
   input  logic                       bus_rst_i,
   input  logic                       set_stb_i,
   input  umtrx_ctrl_pkg::set_addr_t  set_addr_i,
   input  umtrx_ctrl_pkg::set_data_t  set_data_i,
   input  logic [3:0]                 run_status_i,
   output umtrx_ctrl_pkg::led_mask_t  leds_o,
   output umtrx_ctrl_pkg::lms_res_t   lms_res_o,
   output logic                       phy_resetn_o,
   output logic [1:0]                 divsw_o,
   output logic                       bldr_done_o
);

   import umtrx_ctrl_pkg::*;

   led_mask_t led_sw;
   led_mask_t led_src;
   led_mask_t led_hw;
   logic      phy_reset;

   //////////////////////////////////////////////////
   // Misc block

   setting_reg #(.payload_t(lms_res_t), .MY_ADDR(`SR_MISC + `MISC_LMS_RES)) sr_lms_res (
      .wb_clk(wb_clk), .bus_rst_i(bus_rst_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(lms_res_o), .changed_o()
   );

   setting_reg #(.payload_t(led_mask_t), .MY_ADDR(`SR_MISC + `MISC_LED_SW)) sr_led_sw (
      .wb_clk(wb_clk), .bus_rst_i(bus_rst_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(led_sw), .changed_o()
   );

   setting_reg #(.payload_t(logic), .MY_ADDR(`SR_MISC + `MISC_PHY_RESET)) sr_phy (
      .wb_clk(wb_clk), .bus_rst_i(bus_rst_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(phy_reset), .changed_o()
   );

   setting_reg #(.payload_t(logic), .MY_ADDR(`SR_MISC + `MISC_BLDR_DONE)) sr_bldr (
      .wb_clk(wb_clk), .bus_rst_i(bus_rst_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(bldr_done_o), .changed_o()
   );

   // 1 = hardware drives the LED, 0 = software
   setting_reg #(
      .payload_t(led_mask_t),
      .MY_ADDR  (`SR_MISC + `MISC_LED_SRC),
      .AT_RESET (led_mask_t'(`LED_SRC_RESET))
   ) sr_led_src (
      .wb_clk(wb_clk), .bus_rst_i(bus_rst_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(led_src), .changed_o()
   );

   //////////////////////////////////////////////////
   // Diversity switches

   setting_reg #(.payload_t(logic), .MY_ADDR(`SR_DIVSW + 0), .AT_RESET(1'(`DIVSW_RESET))) sr_divsw1 (
      .wb_clk(wb_clk), .bus_rst_i(bus_rst_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(divsw_o[0]), .changed_o()
   );

   setting_reg #(.payload_t(logic), .MY_ADDR(`SR_DIVSW + 1), .AT_RESET(1'(`DIVSW_RESET))) sr_divsw2 (
      .wb_clk(wb_clk), .bus_rst_i(bus_rst_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(divsw_o[1]), .changed_o()
   );

   //////////////////////////////////////////////////
   // LED mux and PHY reset

   // Run flags sit in bits 4..1
   assign led_hw = {3'b000, run_status_i, 1'b0};

   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   assign phy_resetn_o = ~phy_reset;  // PHY reset pin is active low

endmodule

// ==== src/readback_mux.sv ====
// Registered 16-word readback mux with its Wishbone read ack
`include "umtrx_ctrl_cfg.svh"

module readback_mux (
   input  logic                        wb_clk,
   input  logic                        bus_rst_i,
   input  logic                        wb_stb_i,
   input  logic                        wb_we_i,
   input  logic [15:0]                 wb_adr_i,
   input  umtrx_ctrl_pkg::vita_time_t  vita_time_i,
   input  umtrx_ctrl_pkg::vita_time_t  vita_time_pps_i,
   input  logic                        button_i,
   input  logic [1:0]                  aux_ld_i,
   output umtrx_ctrl_pkg::set_data_t   wb_dat_o,
   output logic                        wb_ack_o
);

   import umtrx_ctrl_pkg::*;

   rb_index_t rb_idx;
   set_data_t rb_word;
   set_data_t status_word;
   logic      rd_req;

   assign rb_idx = wb_adr_i[5:2];
   assign rd_req = wb_stb_i & ~wb_we_i & ~wb_ack_o;

   // Lock detects and the button
   assign status_word = {16'h0000, aux_ld_i[1], aux_ld_i[0], button_i, 13'h0000};

   always_comb begin
      case (rb_idx)
         `RB_TIME_HI: rb_word = vita_time_i[63:32];
         `RB_TIME_LO: rb_word = vita_time_i[31:0];
         `RB_COMPAT:  rb_word = `COMPAT_NUM;
         `RB_STATUS:  rb_word = status_word;
         `RB_PPS_HI:  rb_word = vita_time_pps_i[63:32];
         `RB_PPS_LO:  rb_word = vita_time_pps_i[31:0];
         default:     rb_word = '0;
      endcase
   end

   always_ff @(posedge wb_clk) begin
      if (bus_rst_i) begin
         wb_ack_o <= 1'b0;
      end else begin
         wb_ack_o <= rd_req;
      end
   end

   // Word captured on the same edge as the request
   always_ff @(posedge wb_clk) begin
      if (rd_req) begin
         wb_dat_o <= rb_word;
      end
   end

endmodule

// ==== src/setting_reg.sv ====
// Single addressed settings register with typed payload and change pulse
module setting_reg #(
   parameter type      payload_t = logic,
   parameter int       MY_ADDR   = 0,
   parameter payload_t AT_RESET  = '0
) (
   input  logic                       wb_clk,
   input  logic                       bus_rst_i,
   input  logic                       set_stb_i,
   input  umtrx_ctrl_pkg::set_addr_t  set_addr_i,
   input  umtrx_ctrl_pkg::set_data_t  set_data_i,
   output payload_t                   value_o,
   output logic                       changed_o
);

   import umtrx_ctrl_pkg::*;

   localparam int W = $bits(payload_t);

   logic hit;

   assign hit = set_stb_i & (set_addr_i == set_addr_t'(MY_ADDR));

   always_ff @(posedge wb_clk) begin
      if (bus_rst_i) begin
         value_o   <= AT_RESET;
         changed_o <= 1'b0;
      end else begin
         changed_o <= hit;
         // Keep only the low bits of the bus word
         if (hit) begin
            value_o <= payload_t'(set_data_i[W-1:0]);
         end
      end
   end

endmodule

// ==== src/settings_bus.sv ====
// Wishbone write port that issues one settings bus strobe per write
module settings_bus (
   input  logic                       wb_clk,
   input  logic                       bus_rst_i,
   input  logic                       wb_stb_i,
   input  logic                       wb_we_i,
   input  logic [15:0]                wb_adr_i,
   input  umtrx_ctrl_pkg::set_data_t  wb_dat_i,
   output logic                       wb_ack_o,
   output logic                       set_stb_o,
   output umtrx_ctrl_pkg::set_addr_t  set_addr_o,
   output umtrx_ctrl_pkg::set_data_t  set_data_o
);

   logic wr_req;
   logic wr_ack;

   // Held strobe gets exactly one ack
   assign wr_req = wb_stb_i & wb_we_i & ~wr_ack;

   always_ff @(posedge wb_clk) begin
      if (bus_rst_i) begin
         wr_ack <= 1'b0;
      end else begin
         wr_ack <= wr_req;
      end
   end

   // Word address, byte lanes dropped
   always_ff @(posedge wb_clk) begin
      if (wr_req) begin
         set_addr_o <= wb_adr_i[9:2];
         set_data_o <= wb_dat_i;
      end
   end

   // Strobe and ack leave on the same cycle
   assign wb_ack_o  = wr_ack;
   assign set_stb_o = wr_ack;

endmodule

// ==== src/umtrx_ctrl_cfg.svh ====
// Settings addresses, register offsets, reset values, compat number, readback indices
`ifndef UMTRX_CTRL_CFG_SVH
`define UMTRX_CTRL_CFG_SVH

// Settings address bases
`define SR_MISC          0
`define SR_TIME64        10
`define SR_DIVSW         180

// Offsets within the misc block
`define MISC_LMS_RES     0
`define MISC_LED_SW      3
`define MISC_PHY_RESET   4
`define MISC_BLDR_DONE   5
`define MISC_LED_SRC     6

// Offsets within the time block, bit 0 of control is "now"
`define TIME_HI          0
`define TIME_LO          1
`define TIME_CTRL        2

// Reset values
`define LED_SRC_RESET    8'h1E
`define DIVSW_RESET      1

// Bump when the register map changes, major 9 minor 0
`define COMPAT_NUM       32'h0009_0000

// Readback word indices
`define RB_TIME_HI       4'd10
`define RB_TIME_LO       4'd11
`define RB_COMPAT        4'd12
`define RB_STATUS        4'd13
`define RB_PPS_HI        4'd14
`define RB_PPS_LO        4'd15

`endif

// ==== src/umtrx_ctrl_pkg.sv ====
// Shared data types for the control slice and the boot FSM state encoding
package umtrx_ctrl_pkg;

   //////////////////////////////////////////////////
   // Settings bus

   // Register address as carried on the settings bus
   typedef logic [7:0]  set_addr_t;

   // Settings write data and readback word
   typedef logic [31:0] set_data_t;

   //////////////////////////////////////////////////
   // Front panel and board control

   // One bit per front panel LED
   typedef logic [7:0]  led_mask_t;

   // Reset lines of the two LMS transceivers
   typedef logic [1:0]  lms_res_t;

   //////////////////////////////////////////////////
   // Timekeeping and readback

   typedef logic [63:0] vita_time_t;

   // Word select for the readback mux, 16 words
   typedef logic [3:0]  rb_index_t;

   // Bootloader handoff
   typedef enum logic {
      BOOT_WAIT = 1'b0,
      BOOT_DONE = 1'b1
   } boot_state_t;

endpackage

// ==== src/umtrx_ctrl_top.sv ====
// Control slice top: Wishbone port, settings, timer, readback and boot reset
module umtrx_ctrl_top (
   input  logic                       wb_clk,
   input  logic                       por_rst,
   // Wishbone slave
   input  logic                       wb_stb_i,
   input  logic                       wb_we_i,
   input  logic [15:0]                wb_adr_i,
   input  umtrx_ctrl_pkg::set_data_t  wb_dat_i,
   output umtrx_ctrl_pkg::set_data_t  wb_dat_o,
   output logic                       wb_ack_o,
   // Board
   input  logic                       pps_i,
   input  logic [3:0]                 run_status_i,
   input  logic                       button_i,
   input  logic [1:0]                 aux_ld_i,
   output umtrx_ctrl_pkg::led_mask_t  leds_o,
   output umtrx_ctrl_pkg::lms_res_t   lms_res_o,
   output logic                       phy_resetn_o,
   output logic [1:0]                 divsw_o,
   output logic                       boot_done_o
);

   import umtrx_ctrl_pkg::*;

   logic       bus_rst;
   logic       bldr_done;
   logic       set_stb;
   set_addr_t  set_addr;
   set_data_t  set_data;
   logic       wr_ack;
   logic       rd_ack;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;

   //////////////////////////////////////////////////
   // Reset and bus

   boot_ctrl u_boot_ctrl (
      .wb_clk(wb_clk), .por_rst(por_rst), .bldr_done_i(bldr_done),
      .bus_rst_o(bus_rst), .boot_done_o(boot_done_o)
   );

   settings_bus u_settings_bus (
      .wb_clk(wb_clk), .bus_rst_i(bus_rst),
      .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
      .wb_ack_o(wr_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data)
   );

   readback_mux u_readback_mux (
      .wb_clk(wb_clk), .bus_rst_i(bus_rst),
      .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .button_i(button_i), .aux_ld_i(aux_ld_i),
      .wb_dat_o(wb_dat_o), .wb_ack_o(rd_ack)
   );

   // Only one of the two can fire per access
   assign wb_ack_o = wr_ack | rd_ack;

   //////////////////////////////////////////////////
   // Settings consumers

   misc_ctrl_regs u_misc_ctrl_regs (
      .wb_clk(wb_clk), .bus_rst_i(bus_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .run_status_i(run_status_i),
      .leds_o(leds_o), .lms_res_o(lms_res_o), .phy_resetn_o(phy_resetn_o),
      .divsw_o(divsw_o), .bldr_done_o(bldr_done)
   );

   vita_timer u_vita_timer (
      .wb_clk(wb_clk), .bus_rst_i(bus_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps)
   );

endmodule

// ==== src/vita_timer.sv ====
// 64-bit VITA time counter with immediate or PPS-timed load and PPS latch
`include "umtrx_ctrl_cfg.svh"

module vita_timer (
   input  logic                        wb_clk,
   input  logic                        bus_rst_i,
   input  logic                        set_stb_i,
   input  umtrx_ctrl_pkg::set_addr_t   set_addr_i,
   input  umtrx_ctrl_pkg::set_data_t   set_data_i,
   input  logic                        pps_i,
   output umtrx_ctrl_pkg::vita_time_t  vita_time_o,
   output umtrx_ctrl_pkg::vita_time_t  vita_time_pps_o
);

   import umtrx_ctrl_pkg::*;

   set_data_t  time_hi;
   set_data_t  time_lo;
   logic       ctrl_now;
   logic       ctrl_changed;
   logic       pps_s1;
   logic       pps_s2;
   logic       pps_d;
   logic       pps_edge;
   logic       armed;
   logic       do_load;
   vita_time_t next_time;

   //////////////////////////////////////////////////
   // Staging registers

   setting_reg #(.payload_t(set_data_t), .MY_ADDR(`SR_TIME64 + `TIME_HI)) sr_time_hi (
      .wb_clk(wb_clk), .bus_rst_i(bus_rst_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(time_hi), .changed_o()
   );

   setting_reg #(.payload_t(set_data_t), .MY_ADDR(`SR_TIME64 + `TIME_LO)) sr_time_lo (
      .wb_clk(wb_clk), .bus_rst_i(bus_rst_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(time_lo), .changed_o()
   );

   // Writing control commits the staged time
   setting_reg #(.payload_t(logic), .MY_ADDR(`SR_TIME64 + `TIME_CTRL)) sr_time_ctrl (
      .wb_clk(wb_clk), .bus_rst_i(bus_rst_i), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(ctrl_now), .changed_o(ctrl_changed)
   );

   //////////////////////////////////////////////////
   // PPS sync and rising edge

   always_ff @(posedge wb_clk) begin
      if (bus_rst_i) begin
         pps_s1 <= 1'b0;
         pps_s2 <= 1'b0;
         pps_d  <= 1'b0;
      end else begin
         pps_s1 <= pps_i;
         pps_s2 <= pps_s1;
         pps_d  <= pps_s2;
      end
   end

   assign pps_edge = pps_s2 & ~pps_d;

   // Timed load waits here for the next edge
   always_ff @(posedge wb_clk) begin
      if (bus_rst_i) begin
         armed <= 1'b0;
      end else if (ctrl_changed & ~ctrl_now) begin
         armed <= 1'b1;
      end else if (pps_edge) begin
         armed <= 1'b0;
      end
   end

   //////////////////////////////////////////////////
   // Counter and PPS latch

   assign do_load = (ctrl_changed & ctrl_now) | (armed & pps_edge);

   always_comb begin
      if (do_load) begin
         next_time = {time_hi, time_lo};
      end else begin
         next_time = vita_time_o + 64'd1;
      end
   end

   // Latch sees the loaded value when a timed load fires
   always_ff @(posedge wb_clk) begin
      if (bus_rst_i) begin
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
      end else begin
         vita_time_o <= next_time;
         if (pps_edge) begin
            vita_time_pps_o <= next_time;
         end
      end
   end

endmodule

// ==== verification/ctrl_checker.sv ====
// Checker: compares DUT outputs and read words, watches boot done, keeps the counts
module ctrl_checker (
   input  logic                       wb_clk,
   input  logic                       wb_ack_i,
   input  umtrx_ctrl_pkg::led_mask_t  leds_i,
   input  umtrx_ctrl_pkg::lms_res_t   lms_res_i,
   input  logic                       phy_resetn_i,
   input  logic [1:0]                 divsw_i,
   input  logic                       boot_done_i
);
   timeunit 1ns;
   timeprecision 100ps;

   import umtrx_ctrl_pkg::*;

   int   checks       = 0;
   int   errors       = 0;
   int   tests        = 0;
   int   test_mark    = 0;
   logic boot_seen    = 1'b0;
   logic boot_dropped = 1'b0;

   //////////////////////////////////////////////////
   // Boot done must hold once it has risen

   always @(negedge wb_clk) begin
      if (boot_done_i) begin
         boot_seen <= 1'b1;
      end else if (boot_seen && !boot_dropped) begin
         boot_dropped <= 1'b1;
         $display("error at %0d ns: boot_done_o got 0 expected 1", $time);
      end
   end

   //////////////////////////////////////////////////
   // Compare tasks

   function automatic int total_errors();
      return errors + (boot_dropped ? 1 : 0);
   endfunction

   task automatic check_bits(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0d ns: %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   // Sampled at a falling edge with the bus idle
   task automatic check_outputs(input led_mask_t exp_leds, input lms_res_t exp_lms,
                                input logic exp_phyn, input logic [1:0] exp_divsw,
                                input logic exp_boot);
      check_bits("wb_ack_o", 64'(wb_ack_i), 64'd0);
      check_bits("leds_o", 64'(leds_i), 64'(exp_leds));
      check_bits("lms_res_o", 64'(lms_res_i), 64'(exp_lms));
      check_bits("phy_resetn_o", 64'(phy_resetn_i), 64'(exp_phyn));
      check_bits("divsw_o", 64'(divsw_i), 64'(exp_divsw));
      check_bits("boot_done_o", 64'(boot_done_i), 64'(exp_boot));
   endtask

   task automatic test_done(input string name);
      int n;
      n         = total_errors() - test_mark;
      test_mark = total_errors();
      tests++;
      if (n == 0) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, n);
      end
   endtask

   task automatic report_counts(output int n_err);
      n_err = total_errors();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, n_err);
   endtask

endmodule

// ==== verification/tb_umtrx_ctrl.sv ====
// Testbench top with clock, reset, Wishbone tasks, LED reference model and the test sequence
`include "umtrx_ctrl_cfg.svh"

module tb_umtrx_ctrl;
   timeunit 1ns;
   timeprecision 100ps;

   import umtrx_ctrl_pkg::*;

   localparam int ACK_TIMEOUT  = 20;
   localparam int BOOT_TIMEOUT = 50;

   localparam set_addr_t A_LMS     = set_addr_t'(`SR_MISC + `MISC_LMS_RES);
   localparam set_addr_t A_LED_SW  = set_addr_t'(`SR_MISC + `MISC_LED_SW);
   localparam set_addr_t A_PHY     = set_addr_t'(`SR_MISC + `MISC_PHY_RESET);
   localparam set_addr_t A_BLDR    = set_addr_t'(`SR_MISC + `MISC_BLDR_DONE);
   localparam set_addr_t A_LED_SRC = set_addr_t'(`SR_MISC + `MISC_LED_SRC);
   localparam set_addr_t A_DIV1    = set_addr_t'(`SR_DIVSW + 0);
   localparam set_addr_t A_DIV2    = set_addr_t'(`SR_DIVSW + 1);
   localparam set_addr_t A_THI     = set_addr_t'(`SR_TIME64 + `TIME_HI);
   localparam set_addr_t A_TLO     = set_addr_t'(`SR_TIME64 + `TIME_LO);
   localparam set_addr_t A_TCTRL   = set_addr_t'(`SR_TIME64 + `TIME_CTRL);

   logic        wb_clk;
   logic        por_rst;
   logic        wb_stb;
   logic        wb_we;
   logic [15:0] wb_adr;
   set_data_t   wb_dat_w;
   set_data_t   wb_dat_r;
   logic        wb_ack;
   logic        pps;
   logic [3:0]  run_status;
   logic        button;
   logic [1:0]  aux_ld;
   led_mask_t   leds;
   lms_res_t    lms_res;
   logic        phy_resetn;
   logic [1:0]  divsw;
   logic        boot_done;
   logic [31:0] cyc;

   // Stimulus scratch
   set_data_t   rd;
   set_data_t   t1;
   set_data_t   t2;
   set_data_t   t_hi;
   set_data_t   t_lo;
   set_data_t   exp_word;
   logic [31:0] c0;
   logic [31:0] c1;
   logic [31:0] c2;
   logic [31:0] c3;
   logic [63:0] full;
   lms_res_t    w_lms;
   logic        w_phy;
   logic [1:0]  w_div;
   led_mask_t   w_sw;
   led_mask_t   w_src;
   int          n_err;

   umtrx_ctrl_top DUT (
      .wb_clk(wb_clk), .por_rst(por_rst),
      .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
      .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
      .pps_i(pps), .run_status_i(run_status), .button_i(button), .aux_ld_i(aux_ld),
      .leds_o(leds), .lms_res_o(lms_res), .phy_resetn_o(phy_resetn),
      .divsw_o(divsw), .boot_done_o(boot_done)
   );

   ctrl_checker u_checker (
      .wb_clk(wb_clk), .wb_ack_i(wb_ack), .leds_i(leds), .lms_res_i(lms_res),
      .phy_resetn_i(phy_resetn), .divsw_i(divsw), .boot_done_i(boot_done)
   );

   initial begin
      wb_clk = 1'b0;
      forever #2 wb_clk = ~wb_clk;
   end

   // Posedge count for spacing reads in strobe time
   initial cyc = 32'd0;
   always @(posedge wb_clk) cyc <= cyc + 32'd1;

   //////////////////////////////////////////////////
   // Helpers

   // Per-bit LED select with the hardware flags in bits 4..1
   function automatic led_mask_t expected_leds(input led_mask_t src, input led_mask_t sw,
                                               input logic [3:0] run);
      led_mask_t hw;
      led_mask_t led;
      hw      = '0;
      hw[4:1] = run;
      for (int b = 0; b < 8; b++) begin
         led[b] = src[b] ? hw[b] : sw[b];
      end
      return led;
   endfunction

   task automatic abort_run(input string why);
      $display("Timeout: %s", why);
      $display("Simulation finished: FAIL");
      $finish;
   endtask

   task automatic idle(input int n);
      repeat (n) @(negedge wb_clk);
   endtask

   task automatic wait_ack();
      int  n;
      logic seen;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < ACK_TIMEOUT) begin
         @(negedge wb_clk);
         seen = wb_ack;
         n++;
      end
      if (!seen) begin
         abort_run("wb_ack_o never came back for a Wishbone access");
      end
   endtask

   task automatic wait_boot_done();
      int n;
      n = 0;
      while (!boot_done && n < BOOT_TIMEOUT) begin
         @(negedge wb_clk);
         n++;
      end
      if (!boot_done) begin
         abort_run("boot_done_o did not rise after the bootloader done write");
      end
   endtask

   task automatic wb_write(input set_addr_t addr, input set_data_t data);
      @(negedge wb_clk);
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_adr   = {6'b000000, addr, 2'b00};
      wb_dat_w = data;
      wait_ack();
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      @(negedge wb_clk);
   endtask

   task automatic wb_read(input rb_index_t idx, output set_data_t data,
                          output logic [31:0] at_cycle);
      @(negedge wb_clk);
      wb_stb   = 1'b1;
      wb_we    = 1'b0;
      wb_adr   = {10'b0000000000, idx, 2'b00};
      at_cycle = cyc;
      wait_ack();
      data   = wb_dat_r;
      wb_stb = 1'b0;
   endtask

   //////////////////////////////////////////////////
   // Test sequence

   initial begin
      void'($urandom(32'hb29));
      por_rst    = 1'b1;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      wb_adr     = '0;
      wb_dat_w   = '0;
      pps        = 1'b0;
      run_status = 4'($urandom);
      button     = 1'b0;
      aux_ld     = 2'b00;
      repeat (5) @(negedge wb_clk);
      por_rst = 1'b0;
      idle(3);

      u_checker.check_outputs(expected_leds(`LED_SRC_RESET, 8'h00, run_status),
                              2'b00, 1'b1, 2'b11, 1'b0);
      wb_read(`RB_COMPAT, rd, c1);
      u_checker.check_bits("wb_dat_o word 12", 64'(rd), 64'(`COMPAT_NUM));
      u_checker.test_done("reset defaults");

      w_lms = 2'($urandom);
      w_phy = 1'($urandom);
      w_div = 2'($urandom);
      w_sw  = 8'($urandom);
      w_src = 8'($urandom);
      wb_write(A_LMS, 32'(w_lms));
      wb_write(A_PHY, 32'(w_phy));
      wb_write(A_DIV1, 32'(w_div[0]));
      wb_write(A_DIV2, 32'(w_div[1]));
      wb_write(A_LED_SW, 32'(w_sw));
      wb_write(A_LED_SRC, 32'(w_src));
      run_status = 4'($urandom);
      idle(1);
      u_checker.check_outputs(expected_leds(w_src, w_sw, run_status),
                              w_lms, ~w_phy, w_div, 1'b0);
      u_checker.test_done("registers and LED mux");

      button = 1'($urandom);
      aux_ld = 2'($urandom);
      exp_word     = '0;
      exp_word[15] = aux_ld[1];
      exp_word[14] = aux_ld[0];
      exp_word[13] = button;
      wb_read(`RB_STATUS, rd, c1);
      u_checker.check_bits("wb_dat_o word 13", 64'(rd), 64'(exp_word));
      for (int i = 0; i < 10; i++) begin
         wb_read(rb_index_t'(i), rd, c1);
         u_checker.check_bits($sformatf("wb_dat_o word %0d", i), 64'(rd), 64'd0);
      end
      u_checker.test_done("status readback");

      // Low word near the top so the high word has to carry
      t_hi = $urandom;
      t_lo = 32'hFFFF_FF80 | 32'($urandom & 32'h3F);
      wb_write(A_THI, t_hi);
      wb_write(A_TLO, t_lo);
      wb_write(A_TCTRL, 32'd1);
      // Counter holds the staged time from the edge after the write returns
      c0 = cyc;
      wb_read(`RB_TIME_LO, t1, c1);
      full = {t_hi, t_lo} + 64'(c1 - c0 - 32'd1);
      u_checker.check_bits("wb_dat_o word 11", 64'(t1), 64'(full[31:0]));
      idle(8 + int'($urandom % 24));
      wb_read(`RB_TIME_LO, t2, c2);
      u_checker.check_bits("wb_dat_o word 11 delta", 64'(t2 - t1), 64'(c2 - c1));
      idle(160);
      wb_read(`RB_TIME_HI, rd, c3);
      full = {t_hi, t_lo} + 64'(c3 - c0 - 32'd1);
      u_checker.check_bits("wb_dat_o word 10", 64'(rd), 64'(full[63:32]));
      u_checker.test_done("immediate load and counting");

      t_hi = $urandom;
      t_lo = $urandom;
      wb_write(A_THI, t_hi);
      wb_write(A_TLO, t_lo);
      wb_write(A_TCTRL, 32'd0);
      pps = 1'b1;
      idle(4);
      pps = 1'b0;
      idle(6);
      wb_read(`RB_PPS_HI, rd, c1);
      u_checker.check_bits("wb_dat_o word 14", 64'(rd), 64'(t_hi));
      wb_read(`RB_PPS_LO, rd, c1);
      u_checker.check_bits("wb_dat_o word 15", 64'(rd), 64'(t_lo));
      u_checker.test_done("PPS-timed load");

      // Move registers off their reset values first
      wb_write(A_LMS, 32'd3);
      wb_write(A_PHY, 32'd1);
      wb_write(A_DIV1, 32'd0);
      wb_write(A_DIV2, 32'd0);
      wb_write(A_LED_SRC, 32'd0);
      wb_write(A_LED_SW, 32'(8'($urandom) | 8'h01));
      wb_write(A_BLDR, 32'd1);
      wait_boot_done();
      idle(20);
      u_checker.check_outputs(expected_leds(`LED_SRC_RESET, 8'h00, run_status),
                              2'b00, 1'b1, 2'b11, 1'b1);
      u_checker.test_done("bootloader handoff");

      u_checker.report_counts(n_err);
      if (n_err == 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

endmodule
